// File: logic/mem_msg_pkg.sv
`default_nettype none

package mem_msg_pkg;

   localparam int ADDR_WIDTH = 16;
   localparam int DATA_WIDTH = 32;

   // Byte address and data word
   typedef logic [ADDR_WIDTH-1:0] addr_t;
   typedef logic [DATA_WIDTH-1:0] data_t;

   typedef enum logic {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_op_e;

   typedef struct packed {
      mem_op_e op;
      addr_t   addr;
      data_t   data;
   } mem_cmd_s;

   // Reads return the stored word, writes echo the written data
   typedef struct packed {
      mem_op_e op;
      addr_t   addr;
      data_t   data;
   } mem_resp_s;

endpackage

`default_nettype wire

// File: logic/system_map_pkg.sv
`default_nettype none

package system_map_pkg;

   // Host region, everything below it is memory
   localparam mem_msg_pkg::addr_t IO_BASE           = 16'hF000;
   localparam mem_msg_pkg::addr_t HOST_SCRATCH_ADDR = IO_BASE + 16'd0;
   localparam mem_msg_pkg::addr_t HOST_PUTCHAR_ADDR = IO_BASE + 16'd4;
   localparam mem_msg_pkg::addr_t HOST_FINISH_ADDR  = IO_BASE + 16'd8;

   localparam int MEM_WORDS   = 1024;
   localparam int MEM_LATENCY = 3;
   localparam int MEM_DEPTH   = 4;
   localparam int ROUTE_DEPTH = 4;

   // Wide enough for MEM_DEPTH loader responses in flight
   localparam int BOOT_COUNT_WIDTH = 3;

   // Word index into memory, from address bits 11:2
   typedef logic [$clog2(MEM_WORDS)-1:0] mem_index_t;
   typedef logic [BOOT_COUNT_WIDTH-1:0]  boot_count_t;
   typedef logic [7:0]                   char_t;

endpackage

`default_nettype wire

// File: logic/mem_model.sv
`default_nettype none

module mem_model
(
   input  wire logic                  clk_i,
   input  wire logic                  reset_i,

   input  wire mem_msg_pkg::mem_cmd_s cmd_i,
   input  wire logic                  cmd_valid_i,
   output logic                       cmd_ready_o,

   output mem_msg_pkg::mem_resp_s     resp_o,
   output logic                       resp_valid_o,
   input  wire logic                  resp_ready_i
);
   import mem_msg_pkg::*;
   import system_map_pkg::*;

   localparam int PTR_WIDTH = $clog2(MEM_DEPTH);
   localparam int CNT_WIDTH = $clog2(MEM_DEPTH + 1);

   data_t                mem [MEM_WORDS];
   mem_index_t           cmd_index;

   mem_resp_s            pipe_data [MEM_LATENCY];
   logic [MEM_LATENCY-1:0] pipe_valid;
   logic                 pipe_out_valid;

   mem_resp_s            q_data [MEM_DEPTH];
   logic [PTR_WIDTH-1:0] q_rd;
   logic [PTR_WIDTH-1:0] q_wr;
   logic [CNT_WIDTH-1:0] q_count;
   logic                 q_empty;
   logic                 q_push;
   logic                 q_pop;

   logic [CNT_WIDTH-1:0] outstanding;
   logic                 cmd_fire;
   logic                 resp_fire;

   assign cmd_index   = cmd_i.addr[$bits(mem_index_t)+1:2];
   assign cmd_ready_o = outstanding < MEM_DEPTH;
   assign cmd_fire    = cmd_valid_i && cmd_ready_o;

   // Queue head goes first; an empty queue lets the pipe output through
   assign q_empty        = q_count == '0;
   assign pipe_out_valid = pipe_valid[MEM_LATENCY-1];
   assign resp_valid_o   = !q_empty || pipe_out_valid;
   assign resp_o         = q_empty ? pipe_data[MEM_LATENCY-1] : q_data[q_rd];
   assign resp_fire      = resp_valid_o && resp_ready_i;
   assign q_pop          = resp_fire && !q_empty;
   assign q_push         = pipe_out_valid && !(q_empty && resp_ready_i);

   always_ff @(posedge clk_i)
   begin
      if (cmd_fire && cmd_i.op == MEM_WRITE)
      begin
         mem[cmd_index] <= cmd_i.data;
      end
      pipe_data[0] <= '{op:   cmd_i.op,
                        addr: cmd_i.addr,
                        data: (cmd_i.op == MEM_WRITE) ? cmd_i.data : mem[cmd_index]};
      for (int i = 1; i < MEM_LATENCY; i++)
      begin
         pipe_data[i] <= pipe_data[i-1];
      end
      if (q_push)
      begin
         q_data[q_wr] <= pipe_data[MEM_LATENCY-1];
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         pipe_valid  <= '0;
         q_rd        <= '0;
         q_wr        <= '0;
         q_count     <= '0;
         outstanding <= '0;
      end
      else
      begin
         // Stages advance every cycle, stalls are absorbed by the queue
         pipe_valid <= {pipe_valid[MEM_LATENCY-2:0], cmd_fire};
         if (q_push)
         begin
            q_wr <= q_wr + 1'b1;
         end
         if (q_pop)
         begin
            q_rd <= q_rd + 1'b1;
         end
         q_count     <= q_count + q_push - q_pop;
         outstanding <= outstanding + cmd_fire - resp_fire;
      end
   end

   // Requests held in the pipe and the queue together
   assert property (@(posedge clk_i) disable iff (reset_i)
      ($countones(pipe_valid) + q_count) <= MEM_DEPTH);

endmodule

`default_nettype wire

// File: logic/mem_owner_select.sv
`default_nettype none

module mem_owner_select
(
   input  wire logic                   clk_i,
   input  wire logic                   reset_i,

   input  wire mem_msg_pkg::mem_cmd_s  boot_cmd_i,
   input  wire logic                   boot_cmd_valid_i,
   input  wire logic                   boot_last_i,
   output logic                        boot_cmd_ready_o,
   output mem_msg_pkg::mem_resp_s      boot_resp_o,
   output logic                        boot_resp_valid_o,
   input  wire logic                   boot_resp_ready_i,

   input  wire mem_msg_pkg::mem_cmd_s  proc_cmd_i,
   input  wire logic                   proc_cmd_valid_i,
   output logic                        proc_cmd_ready_o,
   output mem_msg_pkg::mem_resp_s      proc_resp_o,
   output logic                        proc_resp_valid_o,
   input  wire logic                   proc_resp_ready_i,

   output mem_msg_pkg::mem_cmd_s       mem_cmd_o,
   output logic                        mem_cmd_valid_o,
   input  wire logic                   mem_cmd_ready_i,
   input  wire mem_msg_pkg::mem_resp_s mem_resp_i,
   input  wire logic                   mem_resp_valid_i,
   output logic                        mem_resp_ready_o,

   output logic                        boot_done_o
);
   import system_map_pkg::*;

   typedef enum logic [1:0] {
      BOOT,
      DRAIN,
      RUN
   } owner_state_e;

   owner_state_e state;
   boot_count_t  boot_count;
   logic         run;
   logic         boot_cmd_fire;
   logic         boot_resp_fire;

   assign run         = state == RUN;
   assign boot_done_o = run;

   // Loader may only issue while still in BOOT
   assign boot_cmd_ready_o = (state == BOOT) && mem_cmd_ready_i;
   assign proc_cmd_ready_o = run && mem_cmd_ready_i;
   assign mem_cmd_o        = run ? proc_cmd_i : boot_cmd_i;
   assign mem_cmd_valid_o  = run ? proc_cmd_valid_i : (state == BOOT) && boot_cmd_valid_i;

   assign boot_resp_o       = mem_resp_i;
   assign proc_resp_o       = mem_resp_i;
   assign boot_resp_valid_o = !run && mem_resp_valid_i;
   assign proc_resp_valid_o = run && mem_resp_valid_i;
   assign mem_resp_ready_o  = run ? proc_resp_ready_i : boot_resp_ready_i;

   assign boot_cmd_fire  = boot_cmd_valid_i && boot_cmd_ready_o;
   assign boot_resp_fire = boot_resp_valid_o && boot_resp_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state      <= BOOT;
         boot_count <= '0;
      end
      else
      begin
         boot_count <= boot_count + boot_cmd_fire - boot_resp_fire;
         case (state)
            BOOT:
            begin
               if (boot_cmd_fire && boot_last_i)
               begin
                  state <= DRAIN;
               end
            end
            // Wait for the last loader response to be taken
            DRAIN:
            begin
               if (boot_count == '0)
               begin
                  state <= RUN;
               end
            end
            default:
            begin
               state <= RUN;
            end
         endcase
      end
   end

   // Outside RUN every memory response is owed to the loader
   assert property (@(posedge clk_i) disable iff (reset_i)
      (mem_resp_valid_i && !run) |-> (boot_count != '0));

endmodule

`default_nettype wire

// File: logic/addr_router.sv
`default_nettype none

module addr_router
(
   input  wire logic                   clk_i,
   input  wire logic                   reset_i,

   input  wire mem_msg_pkg::mem_cmd_s  cmd_i,
   input  wire logic                   cmd_valid_i,
   output logic                        cmd_ready_o,
   output mem_msg_pkg::mem_resp_s      resp_o,
   output logic                        resp_valid_o,
   input  wire logic                   resp_ready_i,

   output mem_msg_pkg::mem_cmd_s       mem_cmd_o,
   output logic                        mem_cmd_valid_o,
   input  wire logic                   mem_cmd_ready_i,
   input  wire mem_msg_pkg::mem_resp_s mem_resp_i,
   input  wire logic                   mem_resp_valid_i,
   output logic                        mem_resp_ready_o,

   output mem_msg_pkg::mem_cmd_s       host_cmd_o,
   output logic                        host_cmd_valid_o,
   input  wire logic                   host_cmd_ready_i,
   input  wire mem_msg_pkg::mem_resp_s host_resp_i,
   input  wire logic                   host_resp_valid_i,
   output logic                        host_resp_ready_o
);
   import system_map_pkg::*;

   localparam int PTR_WIDTH = $clog2(ROUTE_DEPTH);
   localparam int CNT_WIDTH = $clog2(ROUTE_DEPTH + 1);

   // One bit per request in flight, set for host
   logic [ROUTE_DEPTH-1:0] order_q;
   logic [PTR_WIDTH-1:0]   order_rd;
   logic [PTR_WIDTH-1:0]   order_wr;
   logic [CNT_WIDTH-1:0]   order_count;
   logic                   order_full;
   logic                   order_empty;
   logic                   head_host;

   logic                   to_host;
   logic                   cmd_fire;
   logic                   resp_fire;

   assign to_host     = cmd_i.addr >= IO_BASE;
   assign order_full  = order_count == ROUTE_DEPTH;
   assign order_empty = order_count == '0;
   assign head_host   = order_q[order_rd];

   assign mem_cmd_o        = cmd_i;
   assign host_cmd_o       = cmd_i;
   assign mem_cmd_valid_o  = cmd_valid_i && !to_host && !order_full;
   assign host_cmd_valid_o = cmd_valid_i && to_host && !order_full;
   assign cmd_ready_o      = !order_full && (to_host ? host_cmd_ready_i : mem_cmd_ready_i);
   assign cmd_fire         = cmd_valid_i && cmd_ready_o;

   // Only the target at the head of the queue may answer
   assign resp_o            = head_host ? host_resp_i : mem_resp_i;
   assign resp_valid_o      = !order_empty && (head_host ? host_resp_valid_i : mem_resp_valid_i);
   assign mem_resp_ready_o  = !order_empty && !head_host && resp_ready_i;
   assign host_resp_ready_o = !order_empty && head_host && resp_ready_i;
   assign resp_fire         = resp_valid_o && resp_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (cmd_fire)
      begin
         order_q[order_wr] <= to_host;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         order_rd    <= '0;
         order_wr    <= '0;
         order_count <= '0;
      end
      else
      begin
         if (cmd_fire)
         begin
            order_wr <= order_wr + 1'b1;
         end
         if (resp_fire)
         begin
            order_rd <= order_rd + 1'b1;
         end
         order_count <= order_count + cmd_fire - resp_fire;
      end
   end

   assert property (@(posedge clk_i) disable iff (reset_i) order_count <= ROUTE_DEPTH);

   // A target never answers a request that was not routed to it
   assert property (@(posedge clk_i) disable iff (reset_i)
      (mem_resp_valid_i || host_resp_valid_i) |-> !order_empty);

endmodule

`default_nettype wire

// File: logic/host_mmio.sv
`default_nettype none

module host_mmio
(
   input  wire logic                  clk_i,
   input  wire logic                  reset_i,

   input  wire mem_msg_pkg::mem_cmd_s cmd_i,
   input  wire logic                  cmd_valid_i,
   output logic                       cmd_ready_o,
   output mem_msg_pkg::mem_resp_s     resp_o,
   output logic                       resp_valid_o,
   input  wire logic                  resp_ready_i,

   output system_map_pkg::char_t      char_o,
   output logic                       char_valid_o,
   output logic                       finish_o,
   output mem_msg_pkg::data_t         finish_code_o
);
   import mem_msg_pkg::*;
   import system_map_pkg::*;

   data_t scratch;
   data_t rd_data;
   logic  cmd_fire;
   logic  is_write;

   // Single response buffer, so no new command until it drains
   assign cmd_ready_o = !resp_valid_o;
   assign cmd_fire    = cmd_valid_i && cmd_ready_o;
   assign is_write    = cmd_i.op == MEM_WRITE;
   assign rd_data     = (cmd_i.addr == HOST_SCRATCH_ADDR) ? scratch : '0;

   always_ff @(posedge clk_i)
   begin
      if (cmd_fire)
      begin
         resp_o <= '{op: cmd_i.op, addr: cmd_i.addr, data: is_write ? cmd_i.data : rd_data};
         if (is_write && cmd_i.addr == HOST_SCRATCH_ADDR)
         begin
            scratch <= cmd_i.data;
         end
         if (is_write && cmd_i.addr == HOST_PUTCHAR_ADDR)
         begin
            char_o <= cmd_i.data[7:0];
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         resp_valid_o  <= 1'b0;
         char_valid_o  <= 1'b0;
         finish_o      <= 1'b0;
         finish_code_o <= '0;
      end
      else
      begin
         if (cmd_fire)
         begin
            resp_valid_o <= 1'b1;
         end
         else if (resp_ready_i)
         begin
            resp_valid_o <= 1'b0;
         end
         char_valid_o <= cmd_fire && is_write && cmd_i.addr == HOST_PUTCHAR_ADDR;
         // Finish is sticky
         if (cmd_fire && is_write && cmd_i.addr == HOST_FINISH_ADDR)
         begin
            finish_o      <= 1'b1;
            finish_code_o <= cmd_i.data;
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/boot_fabric.sv
`default_nettype none

module boot_fabric
(
   input  wire logic                   clk_i,
   input  wire logic                   reset_i,

   input  wire mem_msg_pkg::mem_cmd_s  boot_cmd_i,
   input  wire logic                   boot_cmd_valid_i,
   input  wire logic                   boot_last_i,
   output logic                        boot_cmd_ready_o,
   output mem_msg_pkg::mem_resp_s      boot_resp_o,
   output logic                        boot_resp_valid_o,
   input  wire logic                   boot_resp_ready_i,

   input  wire mem_msg_pkg::mem_cmd_s  proc_cmd_i,
   input  wire logic                   proc_cmd_valid_i,
   output logic                        proc_cmd_ready_o,
   output mem_msg_pkg::mem_resp_s      proc_resp_o,
   output logic                        proc_resp_valid_o,
   input  wire logic                   proc_resp_ready_i,

   output logic                        boot_done_o,
   output system_map_pkg::char_t       char_o,
   output logic                        char_valid_o,
   output logic                        finish_o,
   output mem_msg_pkg::data_t          finish_code_o
);
   import mem_msg_pkg::*;

   // Router to owner select
   mem_cmd_s  pmem_cmd;
   logic      pmem_cmd_valid;
   logic      pmem_cmd_ready;
   mem_resp_s pmem_resp;
   logic      pmem_resp_valid;
   logic      pmem_resp_ready;

   // Router to host
   mem_cmd_s  host_cmd;
   logic      host_cmd_valid;
   logic      host_cmd_ready;
   mem_resp_s host_resp;
   logic      host_resp_valid;
   logic      host_resp_ready;

   // Owner select to memory
   mem_cmd_s  mem_cmd;
   logic      mem_cmd_valid;
   logic      mem_cmd_ready;
   mem_resp_s mem_resp;
   logic      mem_resp_valid;
   logic      mem_resp_ready;

   addr_router router
   (
      .clk_i             (clk_i),
      .reset_i           (reset_i),
      .cmd_i             (proc_cmd_i),
      .cmd_valid_i       (proc_cmd_valid_i),
      .cmd_ready_o       (proc_cmd_ready_o),
      .resp_o            (proc_resp_o),
      .resp_valid_o      (proc_resp_valid_o),
      .resp_ready_i      (proc_resp_ready_i),
      .mem_cmd_o         (pmem_cmd),
      .mem_cmd_valid_o   (pmem_cmd_valid),
      .mem_cmd_ready_i   (pmem_cmd_ready),
      .mem_resp_i        (pmem_resp),
      .mem_resp_valid_i  (pmem_resp_valid),
      .mem_resp_ready_o  (pmem_resp_ready),
      .host_cmd_o        (host_cmd),
      .host_cmd_valid_o  (host_cmd_valid),
      .host_cmd_ready_i  (host_cmd_ready),
      .host_resp_i       (host_resp),
      .host_resp_valid_i (host_resp_valid),
      .host_resp_ready_o (host_resp_ready)
   );

   mem_owner_select owner
   (
      .clk_i             (clk_i),
      .reset_i           (reset_i),
      .boot_cmd_i        (boot_cmd_i),
      .boot_cmd_valid_i  (boot_cmd_valid_i),
      .boot_last_i       (boot_last_i),
      .boot_cmd_ready_o  (boot_cmd_ready_o),
      .boot_resp_o       (boot_resp_o),
      .boot_resp_valid_o (boot_resp_valid_o),
      .boot_resp_ready_i (boot_resp_ready_i),
      .proc_cmd_i        (pmem_cmd),
      .proc_cmd_valid_i  (pmem_cmd_valid),
      .proc_cmd_ready_o  (pmem_cmd_ready),
      .proc_resp_o       (pmem_resp),
      .proc_resp_valid_o (pmem_resp_valid),
      .proc_resp_ready_i (pmem_resp_ready),
      .mem_cmd_o         (mem_cmd),
      .mem_cmd_valid_o   (mem_cmd_valid),
      .mem_cmd_ready_i   (mem_cmd_ready),
      .mem_resp_i        (mem_resp),
      .mem_resp_valid_i  (mem_resp_valid),
      .mem_resp_ready_o  (mem_resp_ready),
      .boot_done_o       (boot_done_o)
   );

   mem_model mem
   (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .cmd_i        (mem_cmd),
      .cmd_valid_i  (mem_cmd_valid),
      .cmd_ready_o  (mem_cmd_ready),
      .resp_o       (mem_resp),
      .resp_valid_o (mem_resp_valid),
      .resp_ready_i (mem_resp_ready)
   );

   host_mmio host
   (
      .clk_i         (clk_i),
      .reset_i       (reset_i),
      .cmd_i         (host_cmd),
      .cmd_valid_i   (host_cmd_valid),
      .cmd_ready_o   (host_cmd_ready),
      .resp_o        (host_resp),
      .resp_valid_o  (host_resp_valid),
      .resp_ready_i  (host_resp_ready),
      .char_o        (char_o),
      .char_valid_o  (char_valid_o),
      .finish_o      (finish_o),
      .finish_code_o (finish_code_o)
   );

endmodule

`default_nettype wire

// File: tb/boot_fabric_tb.sv
`default_nettype none

module boot_fabric_tb;
   import mem_msg_pkg::*;
   import system_map_pkg::*;

   localparam bit PORT_BOOT = 1'b0;
   localparam bit PORT_PROC = 1'b1;

   logic      clk_i;
   logic      reset_i;
   mem_cmd_s  boot_cmd_i;
   logic      boot_cmd_valid_i;
   logic      boot_last_i;
   logic      boot_cmd_ready_o;
   mem_resp_s boot_resp_o;
   logic      boot_resp_valid_o;
   logic      boot_resp_ready_i;
   mem_cmd_s  proc_cmd_i;
   logic      proc_cmd_valid_i;
   logic      proc_cmd_ready_o;
   mem_resp_s proc_resp_o;
   logic      proc_resp_valid_o;
   logic      proc_resp_ready_i;
   logic      boot_done_o;
   char_t     char_o;
   logic      char_valid_o;
   logic      finish_o;
   data_t     finish_code_o;

   // Stimulus table, one entry per step
   string     step_name[$];
   bit        step_port[$];
   mem_cmd_s  step_cmd[$];
   bit        step_last[$];
   data_t     step_exp[$];
   bit        table_loaded;

   // Table indices of commands whose responses are still due
   int        boot_expect[$];
   int        proc_expect[$];

   int        error_count;
   int        check_count;
   int        char_count;
   char_t     char_seen;
   int        exp_char_count;
   char_t     exp_char;
   bit        exp_finish;
   data_t     exp_finish_code;
   logic [31:0] lcg_state;

   boot_fabric dut
   (
      .clk_i             (clk_i),
      .reset_i           (reset_i),
      .boot_cmd_i        (boot_cmd_i),
      .boot_cmd_valid_i  (boot_cmd_valid_i),
      .boot_last_i       (boot_last_i),
      .boot_cmd_ready_o  (boot_cmd_ready_o),
      .boot_resp_o       (boot_resp_o),
      .boot_resp_valid_o (boot_resp_valid_o),
      .boot_resp_ready_i (boot_resp_ready_i),
      .proc_cmd_i        (proc_cmd_i),
      .proc_cmd_valid_i  (proc_cmd_valid_i),
      .proc_cmd_ready_o  (proc_cmd_ready_o),
      .proc_resp_o       (proc_resp_o),
      .proc_resp_valid_o (proc_resp_valid_o),
      .proc_resp_ready_i (proc_resp_ready_i),
      .boot_done_o       (boot_done_o),
      .char_o            (char_o),
      .char_valid_o      (char_valid_o),
      .finish_o          (finish_o),
      .finish_code_o     (finish_code_o)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic add_step(input string name, input bit port, input mem_op_e cmd_op,
                           input addr_t cmd_addr, input data_t cmd_data, input bit last,
                           input data_t exp);
      mem_cmd_s cmd;
      cmd.op   = cmd_op;
      cmd.addr = cmd_addr;
      cmd.data = cmd_data;
      step_name.push_back(name);
      step_port.push_back(port);
      step_cmd.push_back(cmd);
      step_last.push_back(last);
      step_exp.push_back(exp);
   endtask

   task automatic load_table();
      // Boot image, loader responses echo the written data
      add_step("boot_w0", PORT_BOOT, MEM_WRITE, 16'h0000, 32'hA5A5_0000, 0, 32'hA5A5_0000);
      add_step("boot_w1", PORT_BOOT, MEM_WRITE, 16'h0004, 32'h1111_2222, 0, 32'h1111_2222);
      add_step("boot_w2", PORT_BOOT, MEM_WRITE, 16'h0008, 32'h3333_4444, 0, 32'h3333_4444);
      add_step("boot_w3", PORT_BOOT, MEM_WRITE, 16'h000C, 32'h5555_6666, 0, 32'h5555_6666);
      add_step("boot_w4", PORT_BOOT, MEM_WRITE, 16'h0010, 32'h7777_8888, 0, 32'h7777_8888);
      add_step("boot_w5", PORT_BOOT, MEM_WRITE, 16'h0014, 32'h9999_AAAA, 0, 32'h9999_AAAA);
      add_step("boot_w6", PORT_BOOT, MEM_WRITE, 16'h0018, 32'hBBBB_CCCC, 0, 32'hBBBB_CCCC);
      add_step("boot_w7", PORT_BOOT, MEM_WRITE, 16'h001C, 32'hDEAD_BEEF, 1, 32'hDEAD_BEEF);
      add_step("img_r0", PORT_PROC, MEM_READ, 16'h0000, 32'h0, 0, 32'hA5A5_0000);
      add_step("img_r3", PORT_PROC, MEM_READ, 16'h000C, 32'h0, 0, 32'h5555_6666);
      add_step("img_r7", PORT_PROC, MEM_READ, 16'h001C, 32'h0, 0, 32'hDEAD_BEEF);
      add_step("mem_w", PORT_PROC, MEM_WRITE, 16'h0100, 32'hCAFE_F00D, 0, 32'hCAFE_F00D);
      add_step("mem_r", PORT_PROC, MEM_READ, 16'h0100, 32'h0, 0, 32'hCAFE_F00D);
      add_step("scr_w", PORT_PROC, MEM_WRITE, HOST_SCRATCH_ADDR, 32'h0BAD_F00D, 0,
               32'h0BAD_F00D);
      add_step("scr_r", PORT_PROC, MEM_READ, HOST_SCRATCH_ADDR, 32'h0, 0, 32'h0BAD_F00D);
      add_step("putc", PORT_PROC, MEM_WRITE, HOST_PUTCHAR_ADDR, 32'h0000_1241, 0,
               32'h0000_1241);
      // Memory and host reads back to back
      add_step("mix_m1", PORT_PROC, MEM_READ, 16'h0004, 32'h0, 0, 32'h1111_2222);
      add_step("mix_h1", PORT_PROC, MEM_READ, HOST_SCRATCH_ADDR, 32'h0, 0, 32'h0BAD_F00D);
      add_step("mix_m2", PORT_PROC, MEM_READ, 16'h0010, 32'h0, 0, 32'h7777_8888);
      add_step("mix_h2", PORT_PROC, MEM_READ, HOST_PUTCHAR_ADDR, 32'h0, 0, 32'h0);
      add_step("mix_m3", PORT_PROC, MEM_READ, 16'h0018, 32'h0, 0, 32'hBBBB_CCCC);
      add_step("mix_m4", PORT_PROC, MEM_READ, 16'h0100, 32'h0, 0, 32'hCAFE_F00D);
      add_step("mix_h3", PORT_PROC, MEM_READ, HOST_SCRATCH_ADDR, 32'h0, 0, 32'h0BAD_F00D);
      add_step("finish", PORT_PROC, MEM_WRITE, HOST_FINISH_ADDR, 32'h0000_002A, 0,
               32'h0000_002A);
   endtask

   task automatic check_response(input bit port, input data_t actual);
      int idx;
      check_count++;
      if (port == PORT_BOOT)
      begin
         assert (boot_expect.size() > 0)
         else
         begin
            error_count++;
            $display("ERROR: loader response arrived with no command pending");
         end
         if (boot_expect.size() > 0)
         begin
            idx = boot_expect.pop_front();
         end
         else
         begin
            return;
         end
      end
      else
      begin
         assert (proc_expect.size() > 0)
         else
         begin
            error_count++;
            $display("ERROR: processor response arrived with no command pending");
         end
         if (proc_expect.size() > 0)
         begin
            idx = proc_expect.pop_front();
         end
         else
         begin
            return;
         end
      end
      assert (actual == step_exp[idx])
      else
      begin
         error_count++;
         $display("FAIL %s: expected %h, actual %h", step_name[idx], step_exp[idx], actual);
      end
   endtask

   task automatic check_reset_state();
      check_count++;
      assert (!boot_done_o && !finish_o && !char_valid_o && !proc_resp_valid_o &&
              !boot_resp_valid_o && finish_code_o == '0)
      else
      begin
         error_count++;
         $display("ERROR: status and response outputs are not idle after reset");
      end
   endtask

   task automatic issue_step(input int idx);
      @(negedge clk_i);
      if (step_port[idx] == PORT_BOOT)
      begin
         proc_cmd_valid_i = 1'b0;
         boot_cmd_i       = step_cmd[idx];
         boot_last_i      = step_last[idx];
         boot_cmd_valid_i = 1'b1;
         @(posedge clk_i);
         while (!boot_cmd_ready_o)
         begin
            @(posedge clk_i);
         end
         boot_expect.push_back(idx);
      end
      else
      begin
         boot_cmd_valid_i = 1'b0;
         boot_last_i      = 1'b0;
         // Processor waits until memory has been handed over
         while (!boot_done_o)
         begin
            @(negedge clk_i);
         end
         proc_cmd_i       = step_cmd[idx];
         proc_cmd_valid_i = 1'b1;
         @(posedge clk_i);
         while (!proc_cmd_ready_o)
         begin
            @(posedge clk_i);
         end
         proc_expect.push_back(idx);
         if (step_cmd[idx].op == MEM_WRITE && step_cmd[idx].addr == HOST_PUTCHAR_ADDR)
         begin
            exp_char_count++;
            exp_char = step_cmd[idx].data[7:0];
         end
         if (step_cmd[idx].op == MEM_WRITE && step_cmd[idx].addr == HOST_FINISH_ADDR)
         begin
            exp_finish      = 1'b1;
            exp_finish_code = step_cmd[idx].data;
         end
      end
   endtask

   initial
   begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // Random response back-pressure on the processor port
   initial
   begin
      lcg_state         = 32'h521c4d18;
      proc_resp_ready_i = 1'b1;
      forever
      begin
         @(negedge clk_i);
         lcg_state         = lcg_next(lcg_state);
         proc_resp_ready_i = reset_i || (lcg_state[31:30] != 2'b00);
      end
   end

   always @(posedge clk_i)
   begin
      if (!reset_i)
      begin
         if (boot_resp_valid_o && boot_resp_ready_i)
         begin
            check_response(PORT_BOOT, boot_resp_o.data);
            assert (!boot_done_o)
            else
            begin
               error_count++;
               $display("ERROR: loader response seen after memory was handed over");
            end
         end
         if (proc_resp_valid_o && proc_resp_ready_i)
         begin
            check_response(PORT_PROC, proc_resp_o.data);
         end
         if (boot_done_o)
         begin
            assert (boot_expect.size() == 0)
            else
            begin
               error_count++;
               $display("ERROR: boot done raised with loader responses outstanding");
            end
         end
         if (!boot_done_o && proc_cmd_i.addr < IO_BASE)
         begin
            assert (!proc_cmd_ready_o)
            else
            begin
               error_count++;
               $display("ERROR: processor memory command ready before boot done");
            end
         end
         if (char_valid_o)
         begin
            char_count++;
            char_seen = char_o;
         end
      end
   end

   initial
   begin
      wait (table_loaded);
      repeat (step_name.size() * 200) @(posedge clk_i);
      $display("ERROR: watchdog timeout, %0d loader and %0d processor responses pending",
               boot_expect.size(), proc_expect.size());
      $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
      $display("RESULT: FAIL");
      $finish;
   end

   initial
   begin
      reset_i           = 1'b1;
      boot_cmd_i        = '0;
      boot_cmd_valid_i  = 1'b0;
      boot_last_i       = 1'b0;
      boot_resp_ready_i = 1'b1;
      proc_cmd_i        = '0;
      proc_cmd_valid_i  = 1'b0;
      error_count       = 0;
      check_count       = 0;
      char_count        = 0;
      char_seen         = '0;
      exp_char_count    = 0;
      exp_char          = '0;
      exp_finish        = 1'b0;
      exp_finish_code   = '0;
      table_loaded      = 1'b0;
      load_table();
      table_loaded = 1'b1;

      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      check_reset_state();
      reset_i = 1'b0;

      for (int i = 0; i < step_name.size(); i++)
      begin
         issue_step(i);
      end
      @(negedge clk_i);
      boot_cmd_valid_i = 1'b0;
      proc_cmd_valid_i = 1'b0;
      while (boot_expect.size() != 0 || proc_expect.size() != 0)
      begin
         @(negedge clk_i);
      end
      @(negedge clk_i);

      check_count++;
      assert (char_count == exp_char_count && char_seen == exp_char)
      else
      begin
         error_count++;
         $display("FAIL putc_pulse: expected %0d x %h, actual %0d x %h",
                  exp_char_count, exp_char, char_count, char_seen);
      end
      check_count++;
      assert (finish_o == exp_finish && finish_code_o == exp_finish_code)
      else
      begin
         error_count++;
         $display("FAIL finish_code: expected %b/%h, actual %b/%h",
                  exp_finish, exp_finish_code, finish_o, finish_code_o);
      end

      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
      begin
         $display("RESULT: PASS");
      end
      else
      begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
logic/mem_msg_pkg.sv
logic/system_map_pkg.sv
logic/mem_model.sv
logic/mem_owner_select.sv
logic/addr_router.sv
logic/host_mmio.sv
logic/boot_fabric.sv
tb/boot_fabric_tb.sv
